// ==== Makefile ====
# Verilator build and run for the bank front end

VERILATOR ?= verilator
TOP       ?= tb_bank_top
FLIST     ?= bank_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Done: no errors
FAIL_MSG  ?= Done: errors found

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bank_cfg_pkg.sv ====
`default_nettype none

package bank_cfg_pkg;

    // Word geometry
    localparam int WORD_BYTES = 4;
    localparam int WORD_WIDTH = WORD_BYTES * 8;

    // Word address into the data array
    localparam int ADDR_WIDTH  = 8;
    localparam int ARRAY_WORDS = 1 << ADDR_WIDTH;

    localparam int TAG_WIDTH = 6;

    // Lane index bits, never below one
    function automatic int lane_bits(input int num_lanes);
        return (num_lanes > 1) ? $clog2(num_lanes) : 1;
    endfunction

endpackage

`default_nettype wire

// ==== bank_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_checker #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                push,
    input  logic [NUM_LANES-1:0]                                lane_valids,
    input  bank_types_pkg::req_op_e                             op,
    input  logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  tag,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::ADDR_WIDTH-1:0]  addrs,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_BYTES-1:0]  byteens,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_WIDTH-1:0]  wdatas,
    input  logic                                                full,
    input  logic                                                rsp_valid,
    input  logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  rsp_tag,
    input  logic [NUM_LANES-1:0]                                rsp_valids,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_WIDTH-1:0]  rsp_datas,
    input  logic                                                end_of_test,
    output logic                                                idle,
    output logic [31:0]                                         error_count
);

    import bank_cfg_pkg::*;
    import bank_types_pkg::*;

    // Reference memory, with a flag per byte once written
    logic [WORD_WIDTH-1:0]                ref_mem   [ARRAY_WORDS];
    logic [WORD_BYTES-1:0]                ref_known [ARRAY_WORDS];

    // Expected responses, one entry per read packet
    logic [TAG_WIDTH-1:0]                 exp_tag  [$];
    logic [NUM_LANES-1:0]                 exp_mask [$];
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] exp_data [$];
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] exp_care [$];

    logic                                 reset_d;
    logic                                 saw_full;
    int                                   errors;

    assign error_count = errors;

    task automatic record_packet();
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0] data;
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0] care;
        logic [ADDR_WIDTH-1:0]                a;
        data = '0;
        care = '0;
        // Ascending lane order, so a later lane overwrites
        for (int l = 0; l < NUM_LANES; l++) begin
            a = addrs[l];
            if (lane_valids[l] && op == OP_WRITE) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (byteens[l][b]) begin
                        ref_mem[a][b*8 +: 8] = wdatas[l][b*8 +: 8];
                        ref_known[a][b] = 1'b1;
                    end
                end
            end else if (lane_valids[l]) begin
                data[l] = ref_mem[a];
                for (int b = 0; b < WORD_BYTES; b++) begin
                    care[l][b*8 +: 8] = {8{ref_known[a][b]}};
                end
            end
        end
        if (op == OP_READ) begin
            exp_tag.push_back(tag);
            exp_mask.push_back(lane_valids);
            exp_data.push_back(data);
            exp_care.push_back(care);
        end
    endtask

    task automatic check_response();
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0] data;
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0] care;
        logic [NUM_LANES-1:0]                 mask;
        logic [TAG_WIDTH-1:0]                 etag;
        if (exp_tag.size() == 0) begin
            $display("Response with tag %h arrived while no read packet was outstanding",
                     rsp_tag);
            errors++;
        end else begin
            etag = exp_tag.pop_front();
            mask = exp_mask.pop_front();
            data = exp_data.pop_front();
            care = exp_care.pop_front();
            if (rsp_tag !== etag) begin
                $display("Error: rsp_tag got %h expected %h", rsp_tag, etag);
                errors++;
            end
            if (rsp_valids !== mask) begin
                $display("Error: rsp_valids got %h expected %h (tag %h)", rsp_valids, mask, etag);
                errors++;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (mask[l] && ((rsp_datas[l] & care[l]) !== (data[l] & care[l]))) begin
                    $display("Error: rsp_datas[%0d] got %h expected %h (tag %h)",
                             l, rsp_datas[l], data[l], etag);
                    errors++;
                end
            end
        end
    endtask

    task automatic run_final_checks();
        if (exp_tag.size() != 0) begin
            $display("%0d read responses never arrived", exp_tag.size());
            errors += exp_tag.size();
        end
        if (!saw_full) begin
            $display("The queue never reported full during the burst");
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < ARRAY_WORDS; a++) begin
                ref_known[a] = '0;
            end
            exp_tag.delete();
            exp_mask.delete();
            exp_data.delete();
            exp_care.delete();
            saw_full = 1'b0;
            errors   = 0;
        end else begin
            // First edge out of reset
            if (reset_d && full !== 1'b0) begin
                $display("Error: full got %h expected 0 after reset", full);
                errors++;
            end
            if (reset_d && rsp_valid !== 1'b0) begin
                $display("Error: rsp_valid got %h expected 0 after reset", rsp_valid);
                errors++;
            end
            if (full) begin
                saw_full = 1'b1;
            end
            if (rsp_valid) begin
                check_response();
            end
            if (push) begin
                record_packet();
            end
            if (end_of_test) begin
                run_final_checks();
            end
        end
        reset_d = reset;
        idle    = (exp_tag.size() == 0);
    end

endmodule

`default_nettype wire

// ==== bank_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_data_array (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                lane_req,
    input  logic                                lane_write,
    input  logic [bank_cfg_pkg::ADDR_WIDTH-1:0] lane_addr,
    input  logic [bank_cfg_pkg::WORD_BYTES-1:0] lane_byteen,
    input  logic [bank_cfg_pkg::WORD_WIDTH-1:0] lane_wdata,
    output logic                                rd_valid,
    output logic [bank_cfg_pkg::WORD_WIDTH-1:0] rd_data
);

    import bank_cfg_pkg::*;

    logic [WORD_WIDTH-1:0] mem [ARRAY_WORDS];
    logic                  wr_en;
    logic                  rd_en;

    assign wr_en = lane_req && lane_write;
    assign rd_en = lane_req && !lane_write;

    // Byte lanes of the word written independently
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (lane_byteen[b]) begin
                    mem[lane_addr][b*8 +: 8] <= lane_wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[lane_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== bank_top.f ====
bank_cfg_pkg.sv
bank_types_pkg.sv
req_fifo.sv
core_req_queue.sv
bank_data_array.sv
core_rsp_merge.sv
bank_top.sv
bank_checker.sv
tb_bank_top.sv

// ==== bank_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_top #(
    parameter int NUM_LANES   = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                push,
    input  logic [NUM_LANES-1:0]                                lane_valids,
    input  bank_types_pkg::req_op_e                             op,
    input  logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  tag,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::ADDR_WIDTH-1:0]  addrs,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_BYTES-1:0]  byteens,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_WIDTH-1:0]  wdatas,
    output logic                                                full,
    output logic                                                rsp_valid,
    output logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  rsp_tag,
    output logic [NUM_LANES-1:0]                                rsp_valids,
    output logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_WIDTH-1:0]  rsp_datas
);

    import bank_cfg_pkg::*;

    logic                          lane_req;
    logic                          lane_write;
    logic [ADDR_WIDTH-1:0]         lane_addr;
    logic [WORD_BYTES-1:0]         lane_byteen;
    logic [WORD_WIDTH-1:0]         lane_wdata;
    logic [lane_bits(NUM_LANES)-1:0] lane_id;
    logic                          lane_last;
    logic [TAG_WIDTH-1:0]          lane_tag;
    logic                          lane_read;
    logic                          rd_valid;
    logic [WORD_WIDTH-1:0]         rd_data;

    core_req_queue #(
        .NUM_LANES   (NUM_LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .lane_valids (lane_valids),
        .op          (op),
        .tag         (tag),
        .addrs       (addrs),
        .byteens     (byteens),
        .wdatas      (wdatas),
        .full        (full),
        .lane_req    (lane_req),
        .lane_write  (lane_write),
        .lane_addr   (lane_addr),
        .lane_byteen (lane_byteen),
        .lane_wdata  (lane_wdata),
        .lane_id     (lane_id),
        .lane_last   (lane_last),
        .lane_tag    (lane_tag),
        .lane_read   (lane_read)
    );

    bank_data_array u_array (
        .clk         (clk),
        .reset       (reset),
        .lane_req    (lane_req),
        .lane_write  (lane_write),
        .lane_addr   (lane_addr),
        .lane_byteen (lane_byteen),
        .lane_wdata  (lane_wdata),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    core_rsp_merge #(
        .NUM_LANES (NUM_LANES)
    ) u_merge (
        .clk        (clk),
        .reset      (reset),
        .lane_req   (lane_req),
        .lane_id    (lane_id),
        .lane_last  (lane_last),
        .lane_tag   (lane_tag),
        .lane_read  (lane_read),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rsp_valid  (rsp_valid),
        .rsp_tag    (rsp_tag),
        .rsp_valids (rsp_valids),
        .rsp_datas  (rsp_datas)
    );

endmodule

`default_nettype wire

// ==== bank_types_pkg.sv ====
`default_nettype none

package bank_types_pkg;

    // One operation for all lanes of a packet
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    // Lane serializer
    typedef enum logic {
        SER_IDLE  = 1'b0,
        SER_ISSUE = 1'b1
    } ser_state_e;

endpackage

`default_nettype wire

// ==== core_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_req_queue #(
    parameter int NUM_LANES   = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                push,
    input  logic [NUM_LANES-1:0]                                lane_valids,
    input  bank_types_pkg::req_op_e                             op,
    input  logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  tag,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::ADDR_WIDTH-1:0]  addrs,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_BYTES-1:0]  byteens,
    input  logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_WIDTH-1:0]  wdatas,
    output logic                                                full,
    output logic                                                lane_req,
    output logic                                                lane_write,
    output logic [bank_cfg_pkg::ADDR_WIDTH-1:0]                 lane_addr,
    output logic [bank_cfg_pkg::WORD_BYTES-1:0]                 lane_byteen,
    output logic [bank_cfg_pkg::WORD_WIDTH-1:0]                 lane_wdata,
    output logic [bank_cfg_pkg::lane_bits(NUM_LANES)-1:0]       lane_id,
    output logic                                                lane_last,
    output logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  lane_tag,
    output logic                                                lane_read
);

    import bank_cfg_pkg::*;
    import bank_types_pkg::*;

    localparam int LANE_W = lane_bits(NUM_LANES);
    localparam int PKT_W  = NUM_LANES + 1 + TAG_WIDTH
                          + NUM_LANES * (ADDR_WIDTH + WORD_BYTES + WORD_WIDTH);

    logic [PKT_W-1:0]                      pkt_head;
    logic                                  fifo_pop;
    logic                                  fifo_empty;
    logic [NUM_LANES-1:0]                  q_valids;
    logic                                  q_op_bit;
    req_op_e                               q_op;
    logic [TAG_WIDTH-1:0]                  q_tag;
    logic [NUM_LANES-1:0][ADDR_WIDTH-1:0]  q_addrs;
    logic [NUM_LANES-1:0][WORD_BYTES-1:0]  q_byteens;
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0]  q_wdatas;

    ser_state_e                            state;
    logic [NUM_LANES-1:0]                  pending;
    logic [NUM_LANES-1:0]                  avail;
    logic [NUM_LANES-1:0]                  remain;
    logic [LANE_W-1:0]                     sel_idx;
    logic                                  issue;

    req_fifo #(
        .DATA_WIDTH (PKT_W),
        .DEPTH      (QUEUE_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .pop      (fifo_pop),
        .data_in  ({lane_valids, op, tag, addrs, byteens, wdatas}),
        .data_out (pkt_head),
        .empty    (fifo_empty),
        .full     (full)
    );

    assign {q_valids, q_op_bit, q_tag, q_addrs, q_byteens, q_wdatas} = pkt_head;
    assign q_op = req_op_e'(q_op_bit);

    // A fresh packet is served straight from the FIFO head
    assign avail = (state == SER_ISSUE) ? pending
                 : (fifo_empty ? '0 : q_valids);

    // Lowest pending lane wins
    always_comb begin
        sel_idx = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (avail[i]) begin
                sel_idx = LANE_W'(i);
            end
        end
    end

    assign issue    = |avail;
    assign remain   = avail & ~(NUM_LANES'(1) << sel_idx);
    assign fifo_pop = issue && (remain == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SER_IDLE;
            pending   <= '0;
            lane_req  <= 1'b0;
            lane_last <= 1'b0;
        end else begin
            lane_req  <= issue;
            lane_last <= fifo_pop;
            pending   <= remain;
            if (fifo_pop) begin
                state <= SER_IDLE;
            end else if (issue) begin
                state <= SER_ISSUE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            lane_id     <= sel_idx;
            lane_addr   <= q_addrs[sel_idx];
            lane_byteen <= q_byteens[sel_idx];
            lane_wdata  <= q_wdatas[sel_idx];
            lane_tag    <= q_tag;
            lane_write  <= (q_op == OP_WRITE);
            lane_read   <= (q_op == OP_READ);
        end
    end

    a_push_mask: assert property (@(posedge clk) disable iff (reset)
        push |-> (lane_valids != '0))
        else $error("core_req_queue: push with empty lane mask");

    a_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("core_req_queue: push while full");

endmodule

`default_nettype wire

// ==== core_rsp_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_rsp_merge #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                lane_req,
    input  logic [bank_cfg_pkg::lane_bits(NUM_LANES)-1:0]       lane_id,
    input  logic                                                lane_last,
    input  logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  lane_tag,
    input  logic                                                lane_read,
    input  logic                                                rd_valid,
    input  logic [bank_cfg_pkg::WORD_WIDTH-1:0]                 rd_data,
    output logic                                                rsp_valid,
    output logic [bank_cfg_pkg::TAG_WIDTH-1:0]                  rsp_tag,
    output logic [NUM_LANES-1:0]                                rsp_valids,
    output logic [NUM_LANES-1:0][bank_cfg_pkg::WORD_WIDTH-1:0]  rsp_datas
);

    import bank_cfg_pkg::*;
    import bank_types_pkg::*;

    localparam int LANE_W = lane_bits(NUM_LANES);

    logic                 d_req;
    logic                 d_last;
    logic [LANE_W-1:0]    d_id;
    logic [TAG_WIDTH-1:0] d_tag;
    req_op_e              d_op;
    logic [NUM_LANES-1:0] acc_valids;
    logic [NUM_LANES-1:0] lane_bit;
    logic                 rsp_fire;

    // Sideband delayed to meet rd_data
    always_ff @(posedge clk) begin
        if (reset) begin
            d_req <= 1'b0;
        end else begin
            d_req <= lane_req;
        end
    end

    always_ff @(posedge clk) begin
        d_id   <= lane_id;
        d_last <= lane_last;
        d_tag  <= lane_tag;
        d_op   <= lane_read ? OP_READ : OP_WRITE;
    end

    assign lane_bit = NUM_LANES'(1) << d_id;
    assign rsp_fire = d_req && d_last && (d_op == OP_READ);

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid  <= 1'b0;
            acc_valids <= '0;
        end else begin
            rsp_valid <= rsp_fire;
            if (rsp_fire) begin
                acc_valids <= '0;
            end else if (rd_valid) begin
                acc_valids <= acc_valids | lane_bit;
            end
        end
    end

    // Slots double as the response data
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp_datas[d_id] <= rd_data;
        end
        if (rsp_fire) begin
            rsp_tag    <= d_tag;
            rsp_valids <= acc_valids | lane_bit;
        end
    end

    a_rd_lane: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (d_req && d_op == OP_READ))
        else $error("core_rsp_merge: read data without a read lane");

endmodule

`default_nettype wire

// ==== req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter int DATA_WIDTH = 8,
    // Power of two, 2 or more
    parameter int DEPTH      = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  empty,
    output logic                  full
);

    localparam int AW = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [AW:0]           wr_ptr;
    logic [AW:0]           rd_ptr;
    logic [AW:0]           wr_ptr_n;
    logic [AW:0]           rd_ptr_n;

    assign wr_ptr_n = wr_ptr + {{AW{1'b0}}, push};
    assign rd_ptr_n = rd_ptr + {{AW{1'b0}}, pop};

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr_n;
            rd_ptr <= rd_ptr_n;
            empty  <= (wr_ptr_n == rd_ptr_n);
            // Same slot, one lap apart
            full   <= (wr_ptr_n[AW] != rd_ptr_n[AW])
                   && (wr_ptr_n[AW-1:0] == rd_ptr_n[AW-1:0]);
        end
    end

    assign data_out = mem[rd_ptr[AW-1:0]];

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("req_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("req_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== tb_bank_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bank_top;

    import bank_cfg_pkg::*;
    import bank_types_pkg::*;

    localparam int NUM_LANES       = 4;
    localparam int QUEUE_DEPTH     = 4;
    localparam int NUM_ROWS        = 16;
    localparam int FULL_MASK       = (1 << NUM_LANES) - 1;
    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int RESET_CYCLES    = 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * (NUM_LANES + 4) + 50;

    logic                                 clk;
    logic                                 reset;
    logic                                 push;
    logic [NUM_LANES-1:0]                 lane_valids;
    req_op_e                              op;
    logic [TAG_WIDTH-1:0]                 tag;
    logic [NUM_LANES-1:0][ADDR_WIDTH-1:0] addrs;
    logic [NUM_LANES-1:0][WORD_BYTES-1:0] byteens;
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] wdatas;
    logic                                 full;
    logic                                 rsp_valid;
    logic [TAG_WIDTH-1:0]                 rsp_tag;
    logic [NUM_LANES-1:0]                 rsp_valids;
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] rsp_datas;
    logic                                 end_of_test;
    logic                                 idle;
    logic [31:0]                          error_count;

    // Stimulus table, tag is the row index
    req_op_e                              tbl_op    [NUM_ROWS];
    logic [NUM_LANES-1:0]                 tbl_mask  [NUM_ROWS];
    logic [NUM_LANES-1:0][ADDR_WIDTH-1:0] tbl_addrs [NUM_ROWS];
    logic [NUM_LANES-1:0][WORD_BYTES-1:0] tbl_be    [NUM_ROWS];
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] tbl_data  [NUM_ROWS];
    int                                   seed;

    bank_top #(
        .NUM_LANES   (NUM_LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .lane_valids (lane_valids),
        .op          (op),
        .tag         (tag),
        .addrs       (addrs),
        .byteens     (byteens),
        .wdatas      (wdatas),
        .full        (full),
        .rsp_valid   (rsp_valid),
        .rsp_tag     (rsp_tag),
        .rsp_valids  (rsp_valids),
        .rsp_datas   (rsp_datas)
    );

    bank_checker #(
        .NUM_LANES (NUM_LANES)
    ) u_chk (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .lane_valids (lane_valids),
        .op          (op),
        .tag         (tag),
        .addrs       (addrs),
        .byteens     (byteens),
        .wdatas      (wdatas),
        .full        (full),
        .rsp_valid   (rsp_valid),
        .rsp_tag     (rsp_tag),
        .rsp_valids  (rsp_valids),
        .rsp_datas   (rsp_datas),
        .end_of_test (end_of_test),
        .idle        (idle),
        .error_count (error_count)
    );

    // Lane l gets address base + l * stride, all bytes enabled, random data
    task automatic fill_row(input int row, input req_op_e row_op, input int mask,
                            input logic [ADDR_WIDTH-1:0] base, input int stride);
        tbl_op[row]   = row_op;
        tbl_mask[row] = NUM_LANES'(mask);
        for (int l = 0; l < NUM_LANES; l++) begin
            tbl_addrs[row][l] = base + ADDR_WIDTH'(l * stride);
            tbl_be[row][l]    = '1;
            tbl_data[row][l]  = WORD_WIDTH'($random(seed));
        end
    endtask

    task automatic build_table();
        seed = 23;
        fill_row(0, OP_WRITE, 1, 8'h10, 1);
        fill_row(1, OP_READ, 1, 8'h10, 1);
        fill_row(2, OP_WRITE, FULL_MASK, 8'h20, 1);
        // Two lanes on one word, byte 2 enabled in both
        fill_row(3, OP_WRITE, 'b0011, 8'h20, 0);
        tbl_be[3][0] = 4'b0101;
        tbl_be[3][1] = 4'b0110;
        fill_row(4, OP_READ, FULL_MASK, 8'h20, 1);
        fill_row(5, OP_READ, 'b1010, 8'h20, 1);
        fill_row(6, OP_WRITE, FULL_MASK, 8'h40, 1);
        // Back-to-back burst from here on
        fill_row(7, OP_READ, FULL_MASK, 8'h40, 1);
        fill_row(8, OP_WRITE, 'b0100, 8'h40, 1);
        tbl_be[8][2] = 4'b1100;
        fill_row(9, OP_READ, 'b0110, 8'h40, 1);
        fill_row(10, OP_READ, FULL_MASK, 8'h43, -1);
        fill_row(11, OP_WRITE, FULL_MASK, 8'h40, 1);
        fill_row(12, OP_READ, 'b1001, 8'h40, 1);
        fill_row(13, OP_READ, FULL_MASK, 8'h41, 0);
        fill_row(14, OP_WRITE, 'b0001, 8'h10, 1);
        fill_row(15, OP_READ, 'b0001, 8'h10, 1);
    endtask

    task automatic drive_row(input int row);
        push        = 1'b1;
        op          = tbl_op[row];
        tag         = TAG_WIDTH'(row);
        lane_valids = tbl_mask[row];
        addrs       = tbl_addrs[row];
        byteens     = tbl_be[row];
        wdatas      = tbl_data[row];
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run still busy after %0d cycles, %0d errors counted",
                 WATCHDOG_CYCLES, error_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        push        = 1'b0;
        lane_valids = '0;
        op          = OP_READ;
        tag         = '0;
        addrs       = '0;
        byteens     = '0;
        wdatas      = '0;
        end_of_test = 1'b0;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;

        for (int r = 0; r < NUM_ROWS; r++) begin
            while (full) begin
                push = 1'b0;
                @(posedge clk);
                #DRIVE_DELAY;
            end
            drive_row(r);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        push        = 1'b0;
        lane_valids = '0;

        while (!idle) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // Time for a stray response to show up
        repeat (NUM_LANES + 4) @(posedge clk);
        #DRIVE_DELAY;
        end_of_test = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
